//--- sources.f
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/io_regs.sv
source/cpu_top.sv
tb/cpu_props.sv
tb/cpu_tb.sv

//--- tb/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
  import cpu_pkg::*;
();

  // **************************************************
  // Stimulus table
  // **************************************************
  // One program shape per kind of row
  localparam logic [2:0] K_ALUR = 3'd0;
  localparam logic [2:0] K_ALUI = 3'd1;
  localparam logic [2:0] K_MEM  = 3'd2;
  localparam logic [2:0] K_BR   = 3'd3;
  localparam logic [2:0] K_JAL  = 3'd4;
  localparam logic [2:0] K_IO   = 3'd5;

  typedef struct packed {
    logic [2:0]          kind;
    op1_e                op1;
    op2_e                op2;
    logic [15:0]         a;
    logic [15:0]         b;
    logic [KEY_BITS-1:0] key;
    logic [SW_BITS-1:0]  sw;
    logic                to_ledr;
  } row_t;

  logic                 clk;
  logic                 reset;
  logic                 run;
  logic [KEY_BITS-1:0]  key;
  logic [SW_BITS-1:0]   sw;
  logic                 load_valid;
  logic [DBITS-1:0]     load_addr;
  logic [DBITS-1:0]     load_data;
  logic                 load_ready;
  logic [HEX_BITS-1:0]  hex;
  logic [LEDR_BITS-1:0] ledr;

  row_t                 rows[$];
  logic [31:0]          prog[$];
  logic [HEX_BITS-1:0]  exp_hex;
  logic [LEDR_BITS-1:0] exp_ledr;
  int                   hex_errors = 0;
  int                   ledr_errors = 0;
  int                   other_errors = 0;
  int                   cycles = 0;
  int                   limit = 0;

  cpu_top i_cpu_top (
    .clk, .reset, .run, .key, .sw, .load_valid, .load_addr, .load_data,
    .load_ready, .hex, .ledr
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Hung run guard
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic add_row(input logic [2:0] kind, input op1_e op1, input op2_e op2,
                         input logic [15:0] a, input logic [15:0] b,
                         input logic [KEY_BITS-1:0] k, input logic [SW_BITS-1:0] s,
                         input logic to_ledr);
    rows.push_back('{kind, op1, op2, a, b, k, s, to_ledr});
  endtask

  // Register op with random operands
  task automatic rand_alu_row(input op2_e op2);
    int unsigned w;
    w = $urandom;
    add_row(K_ALUR, OP1_ALUR, op2, w[15:0], w[31:16], 4'hF, '0, 1'b0);
  endtask

  // **************************************************
  // Program builder
  // **************************************************
  function automatic logic [31:0] enc_r(op2_e op2, logic [3:0] rd, logic [3:0] rs,
                                        logic [3:0] rt);
    instr_t w;
    w       = '0;
    w.r.op1 = OP1_ALUR;
    w.r.op2 = op2;
    w.r.rd  = rd;
    w.r.rs  = rs;
    w.r.rt  = rt;
    return w;
  endfunction

  function automatic logic [31:0] enc_i(op1_e op1, logic [15:0] imm, logic [3:0] rs,
                                        logic [3:0] rt);
    instr_t w;
    w       = '0;
    w.i.op1 = op1;
    w.i.imm = imm;
    w.i.rs  = rs;
    w.i.rt  = rt;
    return w;
  endfunction

  task automatic build_program(input row_t r);
    logic [15:0] dest;
    dest = r.to_ledr ? ADDR_LEDR[15:0] : ADDR_HEX[15:0];
    prog.delete();
    case (r.kind)
      K_ALUR: begin
        prog.push_back(enc_i(OP1_ADDI, r.a, 4'd0, 4'd1));
        prog.push_back(enc_i(OP1_ADDI, r.b, 4'd0, 4'd2));
        prog.push_back(enc_r(r.op2, 4'd3, 4'd1, 4'd2));
      end
      K_ALUI: begin
        prog.push_back(enc_i(OP1_ADDI, r.a, 4'd0, 4'd1));
        prog.push_back(enc_i(r.op1, r.b, 4'd1, 4'd3));
      end
      K_MEM: begin
        prog.push_back(enc_i(OP1_ADDI, r.a, 4'd0, 4'd1));
        prog.push_back(enc_i(OP1_SW, r.b, 4'd0, 4'd1));
        prog.push_back(enc_i(OP1_LW, r.b, 4'd0, 4'd3));
      end
      K_BR: begin
        prog.push_back(enc_i(OP1_ADDI, r.a, 4'd0, 4'd1));
        prog.push_back(enc_i(OP1_ADDI, r.b, 4'd0, 4'd2));
        prog.push_back(enc_i(OP1_ADDI, 16'h0055, 4'd0, 4'd3));
        // Taken skips the overwrite below
        prog.push_back(enc_i(r.op1, 16'd1, 4'd1, 4'd2));
        prog.push_back(enc_i(OP1_ADDI, 16'h002A, 4'd0, 4'd3));
      end
      K_JAL: begin
        // Jump to START_PC + 8 and link into r3
        prog.push_back(enc_i(OP1_JAL, 16'(((START_PC + 32'd8) >> 2)), 4'd0, 4'd3));
        prog.push_back(enc_i(OP1_ADDI, r.a, 4'd0, 4'd3));
      end
      default: begin
        prog.push_back(enc_i(OP1_LW, r.b, 4'd0, 4'd3));
      end
    endcase
    prog.push_back(enc_i(OP1_SW, dest, 4'd0, 4'd3));
    // Spin in place
    prog.push_back(enc_i(OP1_BEQ, 16'hFFFF, 4'd0, 4'd0));
  endtask

  // **************************************************
  // Reference model
  // **************************************************
  function automatic logic [31:0] model_result(row_t r);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               taken;
    sa = {{16{r.a[15]}}, r.a};
    sb = {{16{r.b[15]}}, r.b};
    case (r.op1)
      OP1_BEQ: taken = (sa == sb);
      OP1_BLT: taken = (sa < sb);
      OP1_BLE: taken = (sa <= sb);
      default: taken = (sa != sb);
    endcase
    case (r.kind)
      K_ALUR: begin
        case (r.op2)
          OP2_EQ:   return {31'b0, sa == sb};
          OP2_LT:   return {31'b0, sa < sb};
          OP2_LE:   return {31'b0, sa <= sb};
          OP2_NE:   return {31'b0, sa != sb};
          OP2_ADD:  return sa + sb;
          OP2_SUB:  return sa - sb;
          OP2_AND:  return sa & sb;
          OP2_OR:   return sa | sb;
          OP2_XOR:  return sa ^ sb;
          OP2_NAND: return ~(sa & sb);
          OP2_NOR:  return ~(sa | sb);
          OP2_NXOR: return ~(sa ^ sb);
          OP2_RSHF: return sa >>> sb[4:0];
          default:  return sa << sb[4:0];
        endcase
      end
      K_ALUI: begin
        case (r.op1)
          OP1_ADDI: return sa + sb;
          OP1_ANDI: return sa & sb;
          OP1_ORI:  return sa | sb;
          default:  return sa ^ sb;
        endcase
      end
      K_MEM:   return sa;
      K_BR:    return taken ? 32'h55 : 32'h2A;
      K_JAL:   return START_PC + 32'd4;
      default: return (r.b == ADDR_KEY[15:0]) ? {28'b0, ~r.key} : {22'b0, r.sw};
    endcase
  endfunction

  // **************************************************
  // Compare tasks and boot port
  // **************************************************
  task automatic check_hex(input int row, input logic [HEX_BITS-1:0] got,
                           input logic [HEX_BITS-1:0] exp);
    if (got !== exp) begin
      hex_errors++;
      $display("mismatch hex row %0d: got %h expected %h", row, got, exp);
    end
  endtask

  task automatic check_ledr(input int row, input logic [LEDR_BITS-1:0] got,
                            input logic [LEDR_BITS-1:0] exp);
    if (got !== exp) begin
      ledr_errors++;
      $display("mismatch ledr row %0d: got %h expected %h", row, got, exp);
    end
  endtask

  task automatic check_ready(input int row, input logic got, input logic exp);
    if (got !== exp) begin
      other_errors++;
      $display("mismatch load_ready row %0d: got %h expected %h", row, got, exp);
    end
  endtask

  // One word per accepted handshake
  task automatic boot_word(input logic [DBITS-1:0] addr, input logic [DBITS-1:0] data);
    @(negedge clk);
    load_valid = 1'b1;
    load_addr  = addr;
    load_data  = data;
    @(posedge clk);
    while (!load_ready)
      @(posedge clk);
  endtask

  // **************************************************
  // Main sequence
  // **************************************************
  initial begin
    row_t        r;
    logic [31:0] res;
    int unsigned seed;
    int          prop_errors;
    reset      = 1'b1;
    run        = 1'b0;
    key        = 4'hF;
    sw         = '0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    seed       = 32'h527f;
    void'($urandom(seed));

    // Register ops with random operands plus a few directed corners
    rand_alu_row(OP2_ADD);
    rand_alu_row(OP2_SUB);
    rand_alu_row(OP2_AND);
    rand_alu_row(OP2_OR);
    rand_alu_row(OP2_XOR);
    rand_alu_row(OP2_NAND);
    rand_alu_row(OP2_NOR);
    rand_alu_row(OP2_NXOR);
    rand_alu_row(OP2_RSHF);
    rand_alu_row(OP2_LSHF);
    rand_alu_row(OP2_LT);
    rand_alu_row(OP2_LE);
    rand_alu_row(OP2_NE);
    add_row(K_ALUR, OP1_ALUR, OP2_EQ, 16'h8001, 16'h8001, 4'hF, '0, 1'b0);
    // Shift far enough that the sign fill shows up in HEX
    add_row(K_ALUR, OP1_ALUR, OP2_RSHF, 16'h8000, 16'h0010, 4'hF, '0, 1'b0);
    // Immediate ops with negative immediates
    add_row(K_ALUI, OP1_ADDI, OP2_ADD, 16'h0010, 16'hFFF0, 4'hF, '0, 1'b0);
    add_row(K_ALUI, OP1_ANDI, OP2_ADD, 16'hF234, 16'hFF0F, 4'hF, '0, 1'b0);
    add_row(K_ALUI, OP1_ORI, OP2_ADD, 16'h0003, 16'h8000, 4'hF, '0, 1'b0);
    add_row(K_ALUI, OP1_XORI, OP2_ADD, 16'h00FF, 16'hFFFF, 4'hF, '0, 1'b0);
    add_row(K_MEM, OP1_LW, OP2_ADD, 16'hBEEF, 16'h0040, 4'hF, '0, 1'b0);
    // Branches alternate taken and not taken
    add_row(K_BR, OP1_BEQ, OP2_ADD, 16'd5, 16'd5, 4'hF, '0, 1'b1);
    add_row(K_BR, OP1_BEQ, OP2_ADD, 16'd5, 16'd6, 4'hF, '0, 1'b1);
    add_row(K_BR, OP1_BLT, OP2_ADD, 16'hFFFE, 16'd1, 4'hF, '0, 1'b1);
    add_row(K_BR, OP1_BLT, OP2_ADD, 16'd1, 16'hFFFE, 4'hF, '0, 1'b1);
    add_row(K_BR, OP1_BLE, OP2_ADD, 16'd3, 16'd3, 4'hF, '0, 1'b1);
    add_row(K_BR, OP1_BLE, OP2_ADD, 16'd4, 16'd3, 4'hF, '0, 1'b1);
    add_row(K_BR, OP1_BNE, OP2_ADD, 16'd1, 16'd2, 4'hF, '0, 1'b1);
    add_row(K_BR, OP1_BNE, OP2_ADD, 16'd7, 16'd7, 4'hF, '0, 1'b1);
    add_row(K_JAL, OP1_JAL, OP2_ADD, 16'h03FF, 16'h0000, 4'hF, '0, 1'b1);
    add_row(K_IO, OP1_LW, OP2_ADD, 16'h0000, ADDR_KEY[15:0], 4'b0101, '0, 1'b1);
    add_row(K_IO, OP1_LW, OP2_ADD, 16'h0000, ADDR_SW[15:0], 4'hF, 10'h2C3, 1'b1);
    limit = rows.size() * 120 + 500;

    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    exp_hex  = HEX_RESET;
    exp_ledr = '0;
    check_hex(-1, hex, exp_hex);
    check_ledr(-1, ledr, exp_ledr);
    check_ready(-1, load_ready, 1'b1);

    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      build_program(r);
      res = model_result(r);
      // Only the destination register moves
      if (r.to_ledr)
        exp_ledr = res[LEDR_BITS-1:0];
      else
        exp_hex = res[HEX_BITS-1:0];
      @(negedge clk);
      key = r.key;
      sw  = r.sw;
      for (int j = 0; j < prog.size(); j++)
        boot_word(START_PC + 32'(4 * j), prog[j]);
      @(negedge clk);
      load_valid = 1'b0;
      run        = 1'b1;
      @(posedge clk);
      check_ready(i, load_ready, 1'b0);
      repeat (60) @(negedge clk);
      check_hex(i, hex, exp_hex);
      check_ledr(i, ledr, exp_ledr);
      run = 1'b0;
    end

    repeat (5) @(negedge clk);
    prop_errors = i_cpu_top.i_cpu_props.fail_count;
    $display("errors: hex %0d, ledr %0d, other %0d, assertions %0d",
             hex_errors, ledr_errors, other_errors, prop_errors);
    if (hex_errors + ledr_errors + other_errors + prop_errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_props
  import cpu_pkg::*;
(
  input wire                 clk,
  input wire                 reset,
  input wire                 run,
  input wire                 load_ready,
  input wire [HEX_BITS-1:0]  hex,
  input wire [LEDR_BITS-1:0] ledr
);

  // Failures seen so far, read by the testbench at the end
  int fail_count = 0;

  // Boot port is open exactly while the core is stopped
  a_ready_follows_run: assert property (@(posedge clk) load_ready == !run)
    else begin
      $error("load_ready does not follow the inverse of run");
      fail_count++;
    end

  // Reset value still visible on the first edge after release
  a_hex_reset: assert property (@(posedge clk) $fell(reset) |-> hex == HEX_RESET)
    else begin
      $error("hex does not hold its reset value after reset");
      fail_count++;
    end

  // Output registers never go unknown once out of reset
  a_outputs_known: assert property (@(posedge clk) disable iff (reset) !$isunknown({hex, ledr}))
    else begin
      $error("hex or ledr carries unknown bits");
      fail_count++;
    end

endmodule

bind cpu_top cpu_props i_cpu_props (.*);

`default_nettype wire

//--- source/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
  import cpu_pkg::*;
#(
  parameter int IMEM_ADDR_BITS = 12,
  parameter int DMEM_ADDR_BITS = 12
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   run,
  input  wire  [KEY_BITS-1:0]   key,
  input  wire  [SW_BITS-1:0]    sw,
  // Boot port into instruction memory
  input  wire                   load_valid,
  input  wire  [DBITS-1:0]      load_addr,
  input  wire  [DBITS-1:0]      load_data,
  output logic                  load_ready,
  output logic [HEX_BITS-1:0]   hex,
  output logic [LEDR_BITS-1:0]  ledr
);

  // Fetch to decode
  logic                  fe_valid;
  instr_t                fe_instr;
  logic [DBITS-1:0]      fe_pc;
  logic                  hold;
  logic                  load_we;
  // Decode to execute
  logic                  id_valid;
  op1_e                  id_op1;
  op2_e                  id_op2;
  logic [DBITS-1:0]      id_val1;
  logic [DBITS-1:0]      id_val2;
  logic [DBITS-1:0]      id_imm;
  logic [DBITS-1:0]      id_pc;
  logic                  id_wr;
  logic [REGNO_BITS-1:0] id_wregno;
  // Execute to memory, plus redirect and hazard report
  logic                  redirect;
  logic [DBITS-1:0]      redirect_pc;
  logic                  ex_wr;
  logic [REGNO_BITS-1:0] ex_wregno;
  logic                  ex_valid;
  logic [DBITS-1:0]      ex_result;
  logic [DBITS-1:0]      ex_store_data;
  logic                  ex_load;
  logic                  ex_store;
  // Memory to decode and to I/O
  logic                  mem_wr;
  logic [REGNO_BITS-1:0] mem_wregno;
  logic                  store_valid;
  logic [DBITS-1:0]      store_addr;
  logic [DBITS-1:0]      store_data;
  logic                  io_hit;
  logic [DBITS-1:0]      io_rdata;
  logic                  wb_valid;
  logic [REGNO_BITS-1:0] wb_regno;
  logic [DBITS-1:0]      wb_data;

  // Boot loading is only open while the core is stopped
  assign load_ready = !run;
  assign load_we    = load_valid && load_ready;

  fetch_stage #(.IMEM_ADDR_BITS(IMEM_ADDR_BITS)) i_fetch_stage (
    .clk, .reset, .run, .hold, .redirect, .redirect_pc,
    .load_we, .load_addr, .load_data,
    .fe_valid, .fe_instr, .fe_pc
  );

  decode_stage i_decode_stage (
    .clk, .reset, .fe_valid, .fe_instr, .fe_pc, .redirect,
    .ex_wr, .ex_wregno, .mem_wr, .mem_wregno, .wb_valid, .wb_regno, .wb_data,
    .hold, .id_valid, .id_op1, .id_op2, .id_val1, .id_val2, .id_imm, .id_pc,
    .id_wr, .id_wregno
  );

  execute_stage i_execute_stage (
    .clk, .reset, .id_valid, .id_op1, .id_op2, .id_val1, .id_val2, .id_imm,
    .id_pc, .id_wr, .id_wregno,
    .redirect, .redirect_pc, .ex_wr, .ex_wregno, .ex_valid, .ex_result,
    .ex_store_data, .ex_load, .ex_store
  );

  memory_stage #(.DMEM_ADDR_BITS(DMEM_ADDR_BITS)) i_memory_stage (
    .clk, .ex_wr, .ex_wregno, .ex_valid, .ex_result, .ex_store_data,
    .ex_load, .ex_store, .io_hit, .io_rdata,
    .mem_wr, .mem_wregno, .store_valid, .store_addr, .store_data,
    .wb_valid, .wb_regno, .wb_data
  );

  // Memory-mapped I/O sits beside the memory stage
  io_regs i_io_regs (
    .clk, .reset, .store_valid, .store_addr, .store_data, .key, .sw,
    .io_hit, .io_rdata, .hex, .ledr
  );

endmodule

`default_nettype wire

//--- source/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs
  import cpu_pkg::*;
(
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  store_valid,
  input  wire  [DBITS-1:0]     store_addr,
  input  wire  [DBITS-1:0]     store_data,
  input  wire  [KEY_BITS-1:0]  key,
  input  wire  [SW_BITS-1:0]   sw,
  output logic                 io_hit,
  output logic [DBITS-1:0]     io_rdata,
  output logic [HEX_BITS-1:0]  hex,
  output logic [LEDR_BITS-1:0] ledr
);

  // **************************************************
  // Output registers
  // **************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex  <= HEX_RESET;
      ledr <= '0;
    end else if (store_valid) begin
      if (store_addr == ADDR_HEX)
        hex <= store_data[HEX_BITS-1:0];
      if (store_addr == ADDR_LEDR)
        ledr <= store_data[LEDR_BITS-1:0];
    end
  end

  // Read side; buttons are active low
  always_comb begin
    io_hit   = 1'b1;
    io_rdata = '0;
    case (store_addr)
      ADDR_KEY:  io_rdata = {{(DBITS-KEY_BITS){1'b0}}, ~key};
      ADDR_SW:   io_rdata = {{(DBITS-SW_BITS){1'b0}}, sw};
      ADDR_HEX:  io_rdata = {{(DBITS-HEX_BITS){1'b0}}, hex};
      ADDR_LEDR: io_rdata = {{(DBITS-LEDR_BITS){1'b0}}, ledr};
      default:   io_hit = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage
  import cpu_pkg::*;
#(
  parameter int DMEM_ADDR_BITS = 12
) (
  input  wire                   clk,
  input  wire                   ex_wr,
  input  wire  [REGNO_BITS-1:0] ex_wregno,
  input  wire                   ex_valid,
  input  wire  [DBITS-1:0]      ex_result,
  input  wire  [DBITS-1:0]      ex_store_data,
  input  wire                   ex_load,
  input  wire                   ex_store,
  input  wire                   io_hit,
  input  wire  [DBITS-1:0]      io_rdata,
  output logic                  mem_wr,
  output logic [REGNO_BITS-1:0] mem_wregno,
  output logic                  store_valid,
  output logic [DBITS-1:0]      store_addr,
  output logic [DBITS-1:0]      store_data,
  output logic                  wb_valid,
  output logic [REGNO_BITS-1:0] wb_regno,
  output logic [DBITS-1:0]      wb_data
);

  localparam int DMEM_WORDS = 1 << (DMEM_ADDR_BITS - 2);

  logic [DBITS-1:0]      dmem [DMEM_WORDS];
  logic                  wr_q;
  logic [REGNO_BITS-1:0] wregno_q;
  logic [DBITS-1:0]      load_data;

  // Destination of the instruction now in this stage, taken alongside the execute latch
  always_ff @(posedge clk) begin
    wr_q     <= ex_wr;
    wregno_q <= ex_wregno;
  end

  assign mem_wr     = ex_valid && wr_q;
  assign mem_wregno = wregno_q;

  // Address goes to io_regs for both loads and stores
  assign store_valid = ex_valid && ex_store;
  assign store_addr  = ex_result;
  assign store_data  = ex_store_data;

  // Data memory only sees addresses io_regs does not claim
  always_ff @(posedge clk) begin
    if (store_valid && !io_hit)
      dmem[ex_result[DMEM_ADDR_BITS-1:2]] <= ex_store_data;
  end

  assign load_data = io_hit ? io_rdata : dmem[ex_result[DMEM_ADDR_BITS-1:2]];

  // Writeback latch
  always_ff @(posedge clk) begin
    wb_valid <= mem_wr;
    wb_regno <= wregno_q;
    wb_data  <= ex_load ? load_data : ex_result;
  end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import cpu_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   id_valid,
  input  wire  op1_e            id_op1,
  input  wire  op2_e            id_op2,
  input  wire  [DBITS-1:0]      id_val1,
  input  wire  [DBITS-1:0]      id_val2,
  input  wire  [DBITS-1:0]      id_imm,
  input  wire  [DBITS-1:0]      id_pc,
  input  wire                   id_wr,
  input  wire  [REGNO_BITS-1:0] id_wregno,
  output logic                  redirect,
  output logic [DBITS-1:0]      redirect_pc,
  output logic                  ex_wr,
  output logic [REGNO_BITS-1:0] ex_wregno,
  output logic                  ex_valid,
  output logic [DBITS-1:0]      ex_result,
  output logic [DBITS-1:0]      ex_store_data,
  output logic                  ex_load,
  output logic                  ex_store
);

  logic signed [DBITS-1:0] a;
  logic signed [DBITS-1:0] b;
  logic [DBITS-1:0]        alu;
  logic                    taken;
  logic [DBITS-1:0]        pc_plus4;
  logic [DBITS-1:0]        imm_x4;

  assign a        = id_val1;
  assign b        = id_val2;
  assign pc_plus4 = id_pc + 32'd4;
  assign imm_x4   = id_imm << 2;

  // Report the instruction held here to decode for hazard checks
  assign ex_wr     = id_valid && id_wr;
  assign ex_wregno = id_wregno;

  // **************************************************
  // ALU
  // **************************************************
  always_comb begin
    alu = '0;
    case (id_op1)
      OP1_ALUR: begin
        case (id_op2)
          OP2_EQ:   alu = {31'b0, a == b};
          OP2_LT:   alu = {31'b0, a < b};
          OP2_LE:   alu = {31'b0, a <= b};
          OP2_NE:   alu = {31'b0, a != b};
          OP2_ADD:  alu = a + b;
          OP2_AND:  alu = a & b;
          OP2_OR:   alu = a | b;
          OP2_XOR:  alu = a ^ b;
          OP2_SUB:  alu = a - b;
          // Bitwise inverted logic ops
          OP2_NAND: alu = ~(a & b);
          OP2_NOR:  alu = ~(a | b);
          OP2_NXOR: alu = ~(a ^ b);
          // Shift amount from low 5 bits, right shift keeps sign
          OP2_RSHF: alu = a >>> b[4:0];
          OP2_LSHF: alu = a << b[4:0];
          default:  alu = '0;
        endcase
      end
      OP1_LW, OP1_SW, OP1_ADDI: alu = id_val1 + id_imm;
      OP1_ANDI: alu = id_val1 & id_imm;
      OP1_ORI:  alu = id_val1 | id_imm;
      OP1_XORI: alu = id_val1 ^ id_imm;
      // Link value
      OP1_JAL:  alu = pc_plus4;
      default:  alu = '0;
    endcase
  end

  // Signed branch condition
  always_comb begin
    case (id_op1)
      OP1_BEQ: taken = (a == b);
      OP1_BLT: taken = (a < b);
      OP1_BLE: taken = (a <= b);
      OP1_BNE: taken = (a != b);
      default: taken = 1'b0;
    endcase
  end

  // Not-taken prediction, so any taken branch or JAL redirects
  assign redirect    = id_valid && (taken || id_op1 == OP1_JAL);
  assign redirect_pc = (id_op1 == OP1_JAL) ? id_val1 + imm_x4 : pc_plus4 + imm_x4;

  // **************************************************
  // Execute latch
  // **************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      ex_valid <= 1'b0;
    else
      ex_valid <= id_valid;
  end

  always_ff @(posedge clk) begin
    ex_result     <= alu;
    ex_store_data <= id_val2;
    ex_load       <= (id_op1 == OP1_LW);
    ex_store      <= (id_op1 == OP1_SW);
  end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import cpu_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   fe_valid,
  input  wire  instr_t          fe_instr,
  input  wire  [DBITS-1:0]      fe_pc,
  input  wire                   redirect,
  // Writers still in flight
  input  wire                   ex_wr,
  input  wire  [REGNO_BITS-1:0] ex_wregno,
  input  wire                   mem_wr,
  input  wire  [REGNO_BITS-1:0] mem_wregno,
  // Register file write port
  input  wire                   wb_valid,
  input  wire  [REGNO_BITS-1:0] wb_regno,
  input  wire  [DBITS-1:0]      wb_data,
  output logic                  hold,
  output logic                  id_valid,
  output op1_e                  id_op1,
  output op2_e                  id_op2,
  output logic [DBITS-1:0]      id_val1,
  output logic [DBITS-1:0]      id_val2,
  output logic [DBITS-1:0]      id_imm,
  output logic [DBITS-1:0]      id_pc,
  output logic                  id_wr,
  output logic [REGNO_BITS-1:0] id_wregno
);

  logic [DBITS-1:0]      regs [1 << REGNO_BITS];
  op1_e                  op1;
  logic [REGNO_BITS-1:0] rs;
  logic [REGNO_BITS-1:0] rt;
  logic                  is_alur;
  logic                  is_alui;
  logic                  is_branch;
  logic                  reads_rt;
  logic                  wr;
  logic [DBITS-1:0]      val1;
  logic [DBITS-1:0]      val2;
  logic                  hazard_rs;
  logic                  hazard_rt;

  // **************************************************
  // Field decode
  // **************************************************
  assign op1 = fe_instr.r.op1;
  assign rs  = fe_instr.r.rs;
  assign rt  = fe_instr.r.rt;

  assign is_alur   = (op1 == OP1_ALUR);
  assign is_alui   = op1 inside {OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};
  assign is_branch = op1 inside {OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE};
  // rs is read by every format; rt only as a source here
  assign reads_rt  = is_alur || is_branch || (op1 == OP1_SW);
  assign wr        = is_alur || is_alui || (op1 == OP1_LW) || (op1 == OP1_JAL);

  // **************************************************
  // Register file with write-through
  // **************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < (1 << REGNO_BITS); i++)
        regs[i] <= '0;
    end else if (wb_valid) begin
      regs[wb_regno] <= wb_data;
    end
  end

  // Same-cycle writeback is forwarded into the read
  assign val1 = (wb_valid && wb_regno == rs) ? wb_data : regs[rs];
  assign val2 = (wb_valid && wb_regno == rt) ? wb_data : regs[rt];

  // Hazard against older writers in execute and memory
  assign hazard_rs = (ex_wr && ex_wregno == rs) || (mem_wr && mem_wregno == rs);
  assign hazard_rt = reads_rt && ((ex_wr && ex_wregno == rt) || (mem_wr && mem_wregno == rt));
  assign hold      = fe_valid && (hazard_rs || hazard_rt);

  // Decode latch valid: bubble on hold, squash on redirect
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      id_valid <= 1'b0;
    else
      id_valid <= fe_valid && !hold && !redirect;
  end

  // Decode latch payload
  always_ff @(posedge clk) begin
    id_op1    <= op1;
    id_op2    <= fe_instr.r.op2;
    id_val1   <= val1;
    id_val2   <= val2;
    id_imm    <= {{(DBITS-IMM_BITS){fe_instr.i.imm[IMM_BITS-1]}}, fe_instr.i.imm};
    id_pc     <= fe_pc;
    id_wr     <= wr;
    id_wregno <= is_alur ? fe_instr.r.rd : rt;
  end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import cpu_pkg::*;
#(
  parameter int IMEM_ADDR_BITS = 12
) (
  input  wire              clk,
  input  wire              reset,
  input  wire              run,
  input  wire              hold,
  input  wire              redirect,
  input  wire  [DBITS-1:0] redirect_pc,
  input  wire              load_we,
  input  wire  [DBITS-1:0] load_addr,
  input  wire  [DBITS-1:0] load_data,
  output logic             fe_valid,
  output instr_t           fe_instr,
  output logic [DBITS-1:0] fe_pc
);

  localparam int IMEM_WORDS = 1 << (IMEM_ADDR_BITS - 2);

  logic [DBITS-1:0] imem [IMEM_WORDS];
  logic [DBITS-1:0] pc;

  // Boot write, word addressed
  always_ff @(posedge clk) begin
    if (load_we)
      imem[load_addr[IMEM_ADDR_BITS-1:2]] <= load_data;
  end

  // PC update; redirect beats hold
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      pc <= START_PC;
    else if (!run)
      pc <= START_PC;
    else if (redirect)
      pc <= redirect_pc;
    else if (!hold)
      pc <= pc + 32'd4;
  end

  // Fetch latch valid bit
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      fe_valid <= 1'b0;
    else if (!run || redirect)
      fe_valid <= 1'b0;
    else if (!hold)
      fe_valid <= 1'b1;
  end

  // Fetch latch payload, frozen while decode holds
  always_ff @(posedge clk) begin
    if (!hold) begin
      fe_instr <= imem[pc[IMEM_ADDR_BITS-1:2]];
      fe_pc    <= pc;
    end
  end

endmodule

`default_nettype wire

//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // **************************************************
  // Widths
  // **************************************************
  localparam int DBITS      = 32;
  localparam int REGNO_BITS = 4;
  localparam int IMM_BITS   = 16;
  localparam int HEX_BITS   = 24;
  localparam int LEDR_BITS  = 10;
  localparam int KEY_BITS   = 4;
  localparam int SW_BITS    = 10;

  // **************************************************
  // Opcodes
  // **************************************************
  // Primary opcode, top 6 bits of every instruction
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // Secondary opcode, only meaningful under OP1_ALUR
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_e;

  // **************************************************
  // Instruction word
  // **************************************************
  // Register format
  typedef struct packed {
    op1_e                  op1;
    op2_e                  op2;
    logic [5:0]            unused;
    logic [REGNO_BITS-1:0] rd;
    logic [REGNO_BITS-1:0] rs;
    logic [REGNO_BITS-1:0] rt;
  } instr_r_t;

  // Immediate format, imm overlaps op2 and rd
  typedef struct packed {
    op1_e                  op1;
    logic [1:0]            unused;
    logic [IMM_BITS-1:0]   imm;
    logic [REGNO_BITS-1:0] rs;
    logic [REGNO_BITS-1:0] rt;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_t;

  // **************************************************
  // Address map and reset values
  // **************************************************
  localparam logic [DBITS-1:0]    START_PC  = 32'h100;
  localparam logic [DBITS-1:0]    ADDR_HEX  = 32'hFFFFF000;
  localparam logic [DBITS-1:0]    ADDR_LEDR = 32'hFFFFF020;
  localparam logic [DBITS-1:0]    ADDR_KEY  = 32'hFFFFF080;
  localparam logic [DBITS-1:0]    ADDR_SW   = 32'hFFFFF090;
  localparam logic [HEX_BITS-1:0] HEX_RESET = 24'hFEDEAD;

endpackage

`default_nettype wire
